// File: frame_rx.sv
/*
 * frame decoder
 * finds the opening "&&", stores the payload and ends on
 * the closing "&&" with rx_done, or on a framing error
 */
`timescale 1ns/1ps

module frame_rx import uart_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  uart_byte_t  rx_byte,
	input  logic        rx_valid,
	output frame_t      rx_frame,
	output logic        rx_done,
	output logic        rx_error,
	output logic        rx_busy
);

	localparam logic [3:0] R_IDLE    = 4'b0001,
	                       R_OPEN    = 4'b0010,
	                       R_PAYLOAD = 4'b0100,
	                       R_CLOSE   = 4'b1000;

	logic [3:0]                 state;
	logic [7:0]                 byte_cnt;
	uart_byte_t [MAX_LEN-1:0]   work_data;
	logic                       is_delim;
	logic                       buf_full;

	assign is_delim = (rx_byte == FRAME_DELIM);
	assign buf_full = (byte_cnt == 8'(MAX_LEN));
	assign rx_busy  = (state != R_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= R_IDLE;
			byte_cnt <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			rx_frame <= '0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_valid) begin
				case (state)
					R_IDLE: begin
						if (is_delim) state <= R_OPEN;
					end
					// a lone '&' outside a frame is just noise
					R_OPEN: begin
						byte_cnt <= '0;
						state    <= is_delim ? R_PAYLOAD : R_IDLE;
					end
					R_PAYLOAD: begin
						if (is_delim) begin
							state <= R_CLOSE;
						end else if (buf_full) begin
							rx_error <= 1'b1;
							byte_cnt <= '0;
							state    <= R_IDLE;
						end else begin
							byte_cnt <= byte_cnt + 8'd1;
						end
					end
					R_CLOSE: begin
						if (is_delim) begin
							rx_frame.length <= byte_cnt;
							rx_frame.data   <= work_data;
							rx_done         <= 1'b1;
						end else begin
							// '&' inside the payload
							rx_error <= 1'b1;
						end
						byte_cnt <= '0;
						state    <= R_IDLE;
					end
					default: state <= R_IDLE;
				endcase
			end
		end
	end

	// bytes past the length read as zero
	always_ff @(posedge sys_clk) begin
		if (rx_valid) begin
			if (state == R_OPEN && is_delim) begin
				work_data <= '0;
			end else if (state == R_PAYLOAD && !is_delim && !buf_full) begin
				work_data[byte_cnt[BYTE_IDX_W-1:0]] <= rx_byte;
			end
		end
	end

endmodule

// File: frame_tx.sv
/*
 * frame sender
 * one-hot FSM sending "&&", the payload bytes, then "&&"
 * through the byte transmitter
 */
`timescale 1ns/1ps

module frame_tx import uart_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  frame_t      tx_frame,
	input  logic        tx_req,
	input  logic        byte_busy,
	input  logic        byte_done,
	output logic        tx_busy,
	output logic        tx_done,
	output uart_byte_t  byte_data,
	output logic        byte_start
);

	localparam logic [6:0] ST_IDLE    = 7'b000_0001,
	                       ST_OPEN1   = 7'b000_0010,
	                       ST_OPEN2   = 7'b000_0100,
	                       ST_PAYLOAD = 7'b000_1000,
	                       ST_CLOSE1  = 7'b001_0000,
	                       ST_CLOSE2  = 7'b010_0000,
	                       ST_FINISH  = 7'b100_0000;

	logic [6:0]     state;
	frame_t         frame_q;
	logic [7:0]     byte_cnt;
	logic           send_pend;
	logic           accept;
	logic           last_byte;
	logic           more_bytes;

	assign tx_busy    = (state != ST_IDLE) && (state != ST_FINISH);
	assign tx_done    = (state == ST_FINISH);
	assign accept     = tx_req && !tx_busy;
	assign last_byte  = (byte_cnt + 8'd1 == frame_q.length);
	// another character follows the one just finished
	assign more_bytes = (state == ST_OPEN1) || (state == ST_OPEN2) ||
	                    (state == ST_PAYLOAD) || (state == ST_CLOSE1);

	assign byte_start = send_pend && !byte_busy;
	assign byte_data  = (state == ST_PAYLOAD) ? frame_q.data[byte_cnt[BYTE_IDX_W-1:0]]
	                                          : FRAME_DELIM;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= ST_IDLE;
			byte_cnt  <= '0;
			send_pend <= 1'b0;
		end else begin
			if (accept || (byte_done && more_bytes)) begin
				send_pend <= 1'b1;
			end else if (byte_start) begin
				send_pend <= 1'b0;
			end
			case (state)
				// finish also takes a new request, tx_busy is already low
				ST_IDLE, ST_FINISH: state <= accept ? ST_OPEN1 : ST_IDLE;
				ST_OPEN1: begin
					if (byte_done) state <= ST_OPEN2;
				end
				ST_OPEN2: begin
					if (byte_done) begin
						byte_cnt <= '0;
						state    <= (frame_q.length == 8'd0) ? ST_CLOSE1 : ST_PAYLOAD;
					end
				end
				ST_PAYLOAD: begin
					if (byte_done) begin
						if (last_byte) begin
							state <= ST_CLOSE1;
						end else begin
							byte_cnt <= byte_cnt + 8'd1;
						end
					end
				end
				ST_CLOSE1: begin
					if (byte_done) state <= ST_CLOSE2;
				end
				ST_CLOSE2: begin
					if (byte_done) state <= ST_FINISH;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// frame held for the whole transfer, oversize lengths clipped
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			frame_q.data   <= tx_frame.data;
			frame_q.length <= (tx_frame.length > 8'(MAX_LEN)) ? 8'(MAX_LEN) : tx_frame.length;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/bash
# compile the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_uart_string_link \
	-f uart_string_link.f \
	-o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"

// File: tb_uart_string_link.sv
/*
 * testbench for the framed string link
 * clock and reset, loopback and direct serial stimulus,
 * reference frame decoder, pulse monitor, compare tasks and summary
 */
`timescale 1ns/1ps

module tb_uart_string_link import uart_pkg::*; ();

	localparam int CLKS_PER_BIT = 8;
	localparam int CHAR_CYCLES  = 10 * CLKS_PER_BIT;
	localparam int N_LOOP       = 8;
	localparam int SETTLE_CHARS = 2;
	// worst-case characters of each test plus its settle time
	localparam int TEST_CHARS   = N_LOOP * (MAX_LEN + 4 + SETTLE_CHARS)
	                            + (MAX_LEN + 4 + SETTLE_CHARS)
	                            + (13 + SETTLE_CHARS)
	                            + (8 + SETTLE_CHARS)
	                            + (27 + SETTLE_CHARS);
	localparam int LIMIT_CYCLES = 20 + TEST_CHARS * CHAR_CYCLES * 3 / 2;

	localparam int REF_IDLE  = 0;
	localparam int REF_OPEN  = 1;
	localparam int REF_BODY  = 2;
	localparam int REF_CLOSE = 3;

	typedef uart_byte_t byte_q_t[$];

	logic       sys_clk;
	logic       sys_rst_n;
	frame_t     tx_frame;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	frame_t     rx_frame;
	logic       rx_done;
	logic       rx_error;
	logic       rx_busy;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       loopback;
	logic       direct_line;

	byte_q_t    stream_q;
	logic       exp_done_q[$];
	frame_t     exp_frame_q[$];
	int         tx_done_cnt = 0;
	int         tx_done_exp = 0;
	int         err_cnt = 0;
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	int         cycle_cnt;
	int         seed;

	// reference decoder state carried from test to test like the DUT
	int         ref_state;
	int         ref_cnt;
	frame_t     ref_work;
	frame_t     ref_last;

	// serial input mux
	assign uart_rx_port = loopback ? uart_tx_port : direct_line;

	uart_string_link #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_frame     (tx_frame),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.rx_busy      (rx_busy),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	task automatic check_frame(input string name, input frame_t want, input frame_t got);
		if (want !== got) begin
			$display("Error: %s expected %h got %h", name, want, got);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		if (want !== got) begin
			$display("Error: %s expected %h got %h", name, want, got);
			err_cnt++;
		end
	endtask

	// framing rules applied to a byte stream
	// one expected outcome queued per done or error
	function automatic void predict_outcomes(input byte_q_t s);
		foreach (s[i]) begin
			case (ref_state)
				REF_IDLE: begin
					if (s[i] == FRAME_DELIM) begin
						ref_state = REF_OPEN;
					end
				end
				REF_OPEN: begin
					if (s[i] == FRAME_DELIM) begin
						ref_work  = '0;
						ref_cnt   = 0;
						ref_state = REF_BODY;
					end else begin
						ref_state = REF_IDLE;
					end
				end
				REF_BODY: begin
					if (s[i] == FRAME_DELIM) begin
						ref_state = REF_CLOSE;
					end else if (ref_cnt == MAX_LEN) begin
						// last good frame stays visible after an overflow
						exp_done_q.push_back(1'b0);
						exp_frame_q.push_back(ref_last);
						ref_state = REF_IDLE;
					end else begin
						ref_work.data[ref_cnt] = s[i];
						ref_cnt++;
					end
				end
				default: begin
					if (s[i] == FRAME_DELIM) begin
						ref_work.length = 8'(ref_cnt);
						ref_last = ref_work;
						exp_done_q.push_back(1'b1);
					end else begin
						exp_done_q.push_back(1'b0);
					end
					exp_frame_q.push_back(ref_last);
					ref_state = REF_IDLE;
				end
			endcase
		end
	endfunction

	// bytes of one frame as they appear on the line
	function automatic void append_frame(input frame_t f);
		int len;
		len = (f.length > MAX_LEN) ? MAX_LEN : int'(f.length);
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(FRAME_DELIM);
		for (int i = 0; i < len; i++) begin
			stream_q.push_back(f.data[i]);
		end
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(FRAME_DELIM);
	endfunction

	function automatic uart_byte_t random_byte();
		uart_byte_t b;
		b = FRAME_DELIM;
		while (b == FRAME_DELIM) begin
			b = 8'($random(seed));
		end
		return b;
	endfunction

	function automatic frame_t random_frame(input int len);
		frame_t f;
		f = '0;
		f.length = 8'(len);
		for (int i = 0; i < len; i++) begin
			f.data[i] = random_byte();
		end
		return f;
	endfunction

	task automatic send_frame(input frame_t f);
		@(posedge sys_clk);
		#2;
		tx_frame = f;
		tx_req   = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req   = 1'b0;
	endtask

	task automatic set_loopback(input logic on);
		@(posedge sys_clk);
		#2;
		loopback = on;
	endtask

	// one bit period on the direct line
	task automatic hold_line(input logic v);
		@(posedge sys_clk);
		#2;
		direct_line = v;
		repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
	endtask

	task automatic send_serial_byte(input uart_byte_t b);
		hold_line(1'b0);
		for (int i = 0; i < 8; i++) begin
			hold_line(b[i]);
		end
		hold_line(1'b1);
	endtask

	task automatic drive_stream();
		foreach (stream_q[i]) begin
			send_serial_byte(stream_q[i]);
		end
	endtask

	task automatic await_outcomes();
		while (exp_done_q.size() != 0 || tx_done_cnt < tx_done_exp) begin
			@(posedge sys_clk);
		end
		// quiet time so that extra pulses get caught
		repeat (SETTLE_CHARS * CHAR_CYCLES) @(posedge sys_clk);
		if (tx_done_cnt != tx_done_exp) begin
			$display("tx_done pulsed %0d times in total where %0d pulses were due",
			         tx_done_cnt, tx_done_exp);
			err_cnt++;
		end
		// decoder back in idle once every outcome is in
		@(negedge sys_clk);
		check_bit("rx_busy", 1'b0, rx_busy);
	endtask

	task automatic end_test(input int num, input string name, input int err_start);
		if (err_cnt == err_start) begin
			pass_cnt++;
			$display("test %0d %s: passed", num, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", num, name, err_cnt - err_start);
		end
	endtask

	// pulse monitor sampling at the falling edge where outputs are stable
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (tx_done) begin
				tx_done_cnt++;
			end
			if (rx_done || rx_error) begin
				if (exp_done_q.size() == 0) begin
					$display("rx_done or rx_error pulsed while no frame outcome was due");
					err_cnt++;
				end else begin
					check_bit("rx_done", exp_done_q[0], rx_done);
					check_bit("rx_error", !exp_done_q[0], rx_error);
					check_frame("rx_frame", exp_frame_q[0], rx_frame);
					void'(exp_done_q.pop_front());
					void'(exp_frame_q.pop_front());
				end
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles, an expected pulse never came", cycle_cnt);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		frame_t f;
		frame_t first;
		int     err_start;
		int     len;
		seed        = 64;
		sys_rst_n   = 1'b0;
		tx_frame    = '0;
		tx_req      = 1'b0;
		loopback    = 1'b1;
		direct_line = 1'b1;
		ref_state   = REF_IDLE;
		ref_cnt     = 0;
		ref_work    = '0;
		ref_last    = '0;
		repeat (10) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;

		err_start = err_cnt;
		@(negedge sys_clk);
		check_bit("tx_busy", 1'b0, tx_busy);
		check_bit("tx_done", 1'b0, tx_done);
		check_bit("rx_done", 1'b0, rx_done);
		check_bit("rx_error", 1'b0, rx_error);
		check_bit("rx_busy", 1'b0, rx_busy);
		check_bit("uart_tx_port", 1'b1, uart_tx_port);
		check_frame("rx_frame", '0, rx_frame);
		end_test(1, "reset values", err_start);

		// lengths 0 and MAX_LEN first and random ones after
		err_start = err_cnt;
		for (int n = 0; n < N_LOOP; n++) begin
			if (n == 0) begin
				len = 0;
			end else if (n == 1) begin
				len = MAX_LEN;
			end else begin
				len = int'($unsigned($random(seed)) % (MAX_LEN + 1));
			end
			f = random_frame(len);
			stream_q.delete();
			append_frame(f);
			predict_outcomes(stream_q);
			tx_done_exp++;
			send_frame(f);
			await_outcomes();
		end
		end_test(2, "loopback frames", err_start);

		err_start = err_cnt;
		first = random_frame(11);
		stream_q.delete();
		append_frame(first);
		predict_outcomes(stream_q);
		tx_done_exp++;
		send_frame(first);
		repeat (3 * CHAR_CYCLES) @(posedge sys_clk);
		f = random_frame(5);
		@(posedge sys_clk);
		#2;
		check_bit("tx_busy", 1'b1, tx_busy);
		// opening delimiters already decoded on the loopback
		check_bit("rx_busy", 1'b1, rx_busy);
		tx_frame = f;
		tx_req   = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req   = 1'b0;
		await_outcomes();
		end_test(3, "request while busy", err_start);

		err_start = err_cnt;
		set_loopback(1'b0);
		stream_q.delete();
		stream_q.push_back(8'h48);
		stream_q.push_back(8'h69);
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(8'h51);
		f = random_frame(5);
		append_frame(f);
		predict_outcomes(stream_q);
		drive_stream();
		await_outcomes();
		end_test(4, "noise before frame", err_start);

		// lone '&' in the payload followed by trailing noise
		err_start = err_cnt;
		stream_q.delete();
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(8'h61);
		stream_q.push_back(8'h62);
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(8'h63);
		stream_q.push_back(8'h64);
		stream_q.push_back(8'h65);
		predict_outcomes(stream_q);
		drive_stream();
		await_outcomes();
		@(negedge sys_clk);
		check_frame("rx_frame", ref_last, rx_frame);
		end_test(5, "lone delimiter in payload", err_start);

		err_start = err_cnt;
		stream_q.delete();
		stream_q.push_back(FRAME_DELIM);
		stream_q.push_back(FRAME_DELIM);
		for (int i = 0; i < MAX_LEN + 1; i++) begin
			stream_q.push_back(random_byte());
		end
		f = random_frame(4);
		append_frame(f);
		predict_outcomes(stream_q);
		drive_stream();
		await_outcomes();
		end_test(6, "payload overflow", err_start);

		$display("passing tests: %0d, failing tests: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: uart_pkg.sv
/*
 * shared definitions for the framed string link:
 * line character type, frame delimiter, payload limit,
 * payload index width and the frame struct
 */
package uart_pkg;

	// one character on the serial line
	typedef logic [7:0] uart_byte_t;

	// framing character, ASCII '&'
	localparam uart_byte_t FRAME_DELIM = 8'h26;

	// largest payload in bytes
	localparam int MAX_LEN = 16;

	// width of an index into the payload bytes
	localparam int BYTE_IDX_W = $clog2(MAX_LEN);

	// one frame as it crosses the top-level ports
	// byte 0 sits in the low bits and goes out first
	typedef struct packed {
		logic [7:0]                  length;
		uart_byte_t [MAX_LEN-1:0]    data;
	} frame_t;

endpackage

// File: uart_rx.sv
/*
 * UART receiver for one byte
 * two-flop input synchronizer, start edge detect,
 * mid-bit sampling and stop bit check
 */
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        rxd,
	output uart_byte_t  rx_byte,
	output logic        rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF  = CLKS_PER_BIT / 2;

	localparam logic [3:0] S_IDLE  = 4'b0001,
	                       S_START = 4'b0010,
	                       S_DATA  = 4'b0100,
	                       S_STOP  = 4'b1000;

	logic [3:0]         state;
	logic               rxd_meta;
	logic               rxd_sync;
	logic               rxd_prev;
	logic [CNT_W-1:0]   clk_cnt;
	logic [2:0]         bit_idx;
	uart_byte_t         shift_q;
	logic               bit_end;
	logic               half_end;

	assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign half_end = (clk_cnt == CNT_W'(HALF - 1));

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (rxd_prev && !rxd_sync) begin
						state <= S_START;
					end
				end
				S_START: begin
					// start bit must still be low at half a bit
					if (half_end) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rxd_sync ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end
				end
				S_STOP: begin
					if (bit_end) begin
						clk_cnt  <= '0;
						rx_valid <= rxd_sync;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && bit_end) begin
			shift_q <= {rxd_sync, shift_q[7:1]};
		end
		if (state == S_STOP && bit_end && rxd_sync) begin
			rx_byte <= shift_q;
		end
	end

endmodule

// File: uart_string_link.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
frame_tx.sv
frame_rx.sv
uart_string_link.sv
tb_uart_string_link.sv

// File: uart_string_link.sv
/*
 * top level of the framed string link
 * frame sender over the UART transmitter, UART receiver
 * under the frame decoder
 */
`timescale 1ns/1ps

module uart_string_link import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic    sys_clk,
	input  logic    sys_rst_n,
	input  frame_t  tx_frame,
	input  logic    tx_req,
	output logic    tx_busy,
	output logic    tx_done,
	output frame_t  rx_frame,
	output logic    rx_done,
	output logic    rx_error,
	output logic    rx_busy,
	input  logic    uart_rx_port,
	output logic    uart_tx_port
);

	uart_byte_t     tx_byte_data;
	logic           tx_byte_start;
	logic           tx_byte_busy;
	logic           tx_byte_done;
	uart_byte_t     rx_byte;
	logic           rx_valid;

	// transmit side
	frame_tx u_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_frame   (tx_frame),
		.tx_req     (tx_req),
		.byte_busy  (tx_byte_busy),
		.byte_done  (tx_byte_done),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_data  (tx_byte_data),
		.byte_start (tx_byte_start)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (tx_byte_data),
		.byte_start (tx_byte_start),
		.txd        (uart_tx_port),
		.byte_busy  (tx_byte_busy),
		.byte_done  (tx_byte_done)
	);

	// receive side
	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rxd        (uart_rx_port),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid)
	);

	frame_rx u_frame_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.rx_frame   (rx_frame),
		.rx_done    (rx_done),
		.rx_error   (rx_error),
		.rx_busy    (rx_busy)
	);

endmodule

// File: uart_tx.sv
/*
 * UART transmitter for one byte
 * start bit, eight data bits lsb first, one stop bit
 */
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  uart_byte_t  byte_data,
	input  logic        byte_start,
	output logic        txd,
	output logic        byte_busy,
	output logic        byte_done
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic [CNT_W-1:0]   clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]         bit_idx;
	uart_byte_t         shift_q;
	logic               bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			txd       <= 1'b1;
			byte_busy <= 1'b0;
			byte_done <= 1'b0;
			clk_cnt   <= '0;
			bit_idx   <= '0;
		end else begin
			byte_done <= 1'b0;
			if (!byte_busy) begin
				if (byte_start) begin
					// start bit goes out on the next cycle
					byte_busy <= 1'b1;
					txd       <= 1'b0;
					clk_cnt   <= '0;
					bit_idx   <= '0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					byte_busy <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					txd     <= shift_q[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// ones shift in from the top, so the stop bit falls out after bit 7
	always_ff @(posedge sys_clk) begin
		if (byte_start && !byte_busy) begin
			shift_q <= byte_data;
		end else if (byte_busy && bit_end && bit_idx != 4'd9) begin
			shift_q <= {1'b1, shift_q[7:1]};
		end
	end

endmodule
